/* common/ray_pkg.sv */
package ray_pkg;

	localparam int frac_bits = 14; // fraction bits of coord_t.

	// one signed q2.14 component.
	typedef logic signed [15:0] coord_t;

	typedef logic [7:0] ray_id_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

	// hit record from the intersection stage.
	typedef struct packed {
		ray_id_t ray_id;
		vector_t p_int;  // intersection point.
		vector_t normal;
		vector_t dir;    // incoming direction.
	} hit_t;

	// ray handed on to the next intersection pass.
	typedef struct packed {
		ray_id_t ray_id;
		vector_t origin;
		vector_t dir;
		logic    is_shadow;
	} ray_t;

endpackage : ray_pkg

/* common/pipe_pkg.sv */
package pipe_pkg;

	localparam int reflect_latency = 3; // reflector stages.
	localparam int fifo_depth = 8;

	// free slots of the output fifo, up to fifo_depth.
	typedef logic [3:0] count_t;

	// fields that ride beside the reflector.
	typedef struct packed {
		ray_pkg::ray_id_t ray_id;
		ray_pkg::vector_t p_int;
	} side_t;

endpackage : pipe_pkg

/* send_reflect/reflector.sv */
`timescale 1ns/1ns

module reflector (
	input  logic             clk,
	input  logic             arst_n,
	input  ray_pkg::vector_t normal,
	input  ray_pkg::vector_t dir,
	output ray_pkg::vector_t reflected
);

	logic signed [31:0] prod_x, prod_y, prod_z;
	logic signed [33:0] dot_sum;
	logic signed [33:0] dot;
	logic signed [49:0] twice_x, twice_y, twice_z;
	ray_pkg::vector_t   normal_1, normal_2;
	ray_pkg::vector_t   dir_1, dir_2;

	// dot product sum before scaling.
	always_comb begin
		dot_sum = prod_x + prod_y + prod_z;
	end

	// twice the projection on the normal.
	always_comb begin
		twice_x = (dot * normal_2.x) >>> (ray_pkg::frac_bits - 1);
		twice_y = (dot * normal_2.y) >>> (ray_pkg::frac_bits - 1);
		twice_z = (dot * normal_2.z) >>> (ray_pkg::frac_bits - 1);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prod_x    <= '0;
			prod_y    <= '0;
			prod_z    <= '0;
			normal_1  <= '0;
			dir_1     <= '0;
			dot       <= '0;
			normal_2  <= '0;
			dir_2     <= '0;
			reflected <= '0;
		end else begin
			// stage 1.
			prod_x   <= normal.x * dir.x;
			prod_y   <= normal.y * dir.y;
			prod_z   <= normal.z * dir.z;
			normal_1 <= normal;
			dir_1    <= dir;
			// stage 2.
			dot      <= dot_sum >>> ray_pkg::frac_bits;
			normal_2 <= normal_1;
			dir_2    <= dir_1;
			// stage 3, wraps to 16 bits.
			reflected.x <= ray_pkg::coord_t'(dir_2.x - twice_x);
			reflected.y <= ray_pkg::coord_t'(dir_2.y - twice_y);
			reflected.z <= ray_pkg::coord_t'(dir_2.z - twice_z);
		end
	end

endmodule : reflector

/* send_reflect/ray_delay_line.sv */
`timescale 1ns/1ns

module ray_delay_line (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             us_valid,
	input  pipe_pkg::side_t  us_data,
	output logic             us_stall,
	output logic             ds_valid,
	output pipe_pkg::side_t  ds_data,
	input  pipe_pkg::count_t free_slots
);

	logic [pipe_pkg::reflect_latency-1:0] valid_q;
	pipe_pkg::side_t                      data_q [pipe_pkg::reflect_latency];
	pipe_pkg::count_t                     in_flight;
	logic                                 accept;

	// entries that still owe a fifo write.
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < pipe_pkg::reflect_latency; i++) begin
			in_flight = in_flight + pipe_pkg::count_t'(valid_q[i]);
		end
	end

	// admit only when every entry in flight keeps a slot.
	assign us_stall = (free_slots <= in_flight);
	assign accept   = us_valid && !us_stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[pipe_pkg::reflect_latency-2:0], accept};
		end
	end

	// payload shifts beside valid_q.
	always_ff @(posedge clk) begin
		data_q[0] <= us_data;
		for (int i = 1; i < pipe_pkg::reflect_latency; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign ds_valid = valid_q[pipe_pkg::reflect_latency-1]; // lines up with reflector output.
	assign ds_data  = data_q[pipe_pkg::reflect_latency-1];

endmodule : ray_delay_line

/* send_reflect/ray_fifo.sv */
`timescale 1ns/1ns

module ray_fifo #(
	parameter int width = 8,
	parameter int depth = pipe_pkg::fifo_depth
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [width-1:0] data_in,
	input  logic             we,
	input  logic             re,
	output logic             full,
	output logic             empty,
	output pipe_pkg::count_t free_slots,
	output logic [width-1:0] data_out
);

	logic [width-1:0]         mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr, rd_ptr;
	pipe_pkg::count_t         count;
	logic                     wr_en, rd_en;

	// wraps for any depth.
	function automatic logic [$clog2(depth)-1:0] next_ptr(
		input logic [$clog2(depth)-1:0] ptr
	);
		if (ptr == $clog2(depth)'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full       = (count == pipe_pkg::count_t'(depth));
	assign empty      = (count == '0);
	assign free_slots = pipe_pkg::count_t'(depth) - count;

	assign wr_en = we && !full;
	assign rd_en = re && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// read and write together keep the count.
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out = mem[rd_ptr]; // head entry, fall-through.

endmodule : ray_fifo

/* send_reflect/send_reflect.sv */
`timescale 1ns/1ns

module send_reflect (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           in_valid,
	input  ray_pkg::hit_t  in_data,
	output logic           in_stall,
	output logic           out_valid,
	output ray_pkg::ray_t  out_data,
	input  logic           out_stall
);

	ray_pkg::vector_t reflected;
	pipe_pkg::side_t  us_data;
	pipe_pkg::side_t  ds_data;
	logic             ds_valid;
	pipe_pkg::count_t free_slots;
	ray_pkg::ray_t    fifo_in;
	logic             fifo_we, fifo_re;
	logic             fifo_full, fifo_empty;

	// direction math runs every cycle.
	reflector reflector_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.normal    (in_data.normal),
		.dir       (in_data.dir),
		.reflected (reflected)
	);

	assign us_data = '{ray_id: in_data.ray_id, p_int: in_data.p_int};

	ray_delay_line ray_delay_line_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.us_valid   (in_valid),
		.us_data    (us_data),
		.us_stall   (in_stall),
		.ds_valid   (ds_valid),
		.ds_data    (ds_data),
		.free_slots (free_slots)
	);

	// reflected rays are never shadow rays.
	assign fifo_in = '{
		ray_id:    ds_data.ray_id,
		origin:    ds_data.p_int,
		dir:       reflected,
		is_shadow: 1'b0
	};

	assign fifo_we   = ds_valid; // credit keeps room.
	assign out_valid = !fifo_empty;
	assign fifo_re   = out_valid && !out_stall;

	ray_fifo #(
		.width ($bits(ray_pkg::ray_t)),
		.depth (pipe_pkg::fifo_depth)
	) ray_fifo_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.data_in    (fifo_in),
		.we         (fifo_we),
		.re         (fifo_re),
		.full       (fifo_full),
		.empty      (fifo_empty),
		.free_slots (free_slots),
		.data_out   (out_data)
	);

endmodule : send_reflect

/* bench/send_reflect_properties.sv */
`timescale 1ns/1ns

module send_reflect_properties (
	input logic             clk,
	input logic             arst_n,
	input logic             in_stall,
	input logic             out_valid,
	input logic             out_stall,
	input ray_pkg::ray_t    out_data,
	input logic             fifo_we,
	input logic             fifo_full,
	input pipe_pkg::count_t free_slots
);

	// stalled output holds its item.
	out_held: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && out_stall) |=> (out_valid && $stable(out_data)))
		else $error("out_data changed while the output was stalled");

	no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
		!(fifo_we && fifo_full))
		else $error("fifo written while full");

	// a read from an empty fifo wraps the count past depth.
	no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
		free_slots <= pipe_pkg::count_t'(pipe_pkg::fifo_depth))
		else $error("fifo read while empty");

	// idle right after reset.
	reset_idle: assert property (@(posedge clk)
		$rose(arst_n) |-> (!out_valid && !in_stall))
		else $error("port not idle after reset");

endmodule : send_reflect_properties

bind send_reflect send_reflect_properties send_reflect_properties_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.in_stall   (in_stall),
	.out_valid  (out_valid),
	.out_stall  (out_stall),
	.out_data   (out_data),
	.fifo_we    (fifo_we),
	.fifo_full  (fifo_full),
	.free_slots (free_slots)
);

/* bench/send_reflect_tb.sv */
`timescale 1ns/1ns

module send_reflect_tb;

	localparam int clk_period      = 40;
	localparam int n_values        = 40;
	localparam int n_backpressure  = 60;
	localparam int total_items     = n_values + n_backpressure + pipe_pkg::fifo_depth + 1;
	localparam int cycles_per_item = 24; // random stalls on both ports.
	localparam int margin_cycles   = 200;

	logic             clk;
	logic             arst_n;
	logic             in_valid;
	ray_pkg::hit_t    in_data;
	logic             in_stall;
	logic             out_valid;
	ray_pkg::ray_t    out_data;
	logic             out_stall;

	logic [15:0]      lfsr_state;
	ray_pkg::ray_id_t next_id;
	ray_pkg::ray_t    expect_q [$];
	string            test_name;
	int               cycle;
	int               accept_cycle;
	bit               latency_mode;

	send_reflect send_reflect_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_stall  (in_stall),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_stall (out_stall)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic ray_pkg::vector_t rand_vector();
		ray_pkg::vector_t v;
		v.x = rand_bits(16);
		v.y = rand_bits(16);
		v.z = rand_bits(16);
		return v;
	endfunction

	function automatic ray_pkg::hit_t make_hit();
		ray_pkg::hit_t hit;
		hit.ray_id = next_id;
		next_id    = next_id + 1'b1; // ids count up, so order shows.
		hit.p_int  = rand_vector();
		hit.normal = rand_vector();
		hit.dir    = rand_vector();
		return hit;
	endfunction

	// r = d - 2 (d.n) n in q2.14, wrapped to 16 bits.
	function automatic ray_pkg::ray_t reflect_ref(input ray_pkg::hit_t hit);
		ray_pkg::ray_t ray;
		longint        n [3];
		longint        d [3];
		longint        dot;
		longint        twice;
		logic [15:0]   r [3];
		n[0] = hit.normal.x;
		n[1] = hit.normal.y;
		n[2] = hit.normal.z;
		d[0] = hit.dir.x;
		d[1] = hit.dir.y;
		d[2] = hit.dir.z;
		dot = 0;
		for (int i = 0; i < 3; i++) begin
			dot += n[i] * d[i];
		end
		dot = dot >>> ray_pkg::frac_bits;
		for (int i = 0; i < 3; i++) begin
			twice = (dot * n[i]) >>> (ray_pkg::frac_bits - 1);
			r[i]  = 16'(d[i] - twice);
		end
		ray.ray_id    = hit.ray_id;
		ray.origin    = hit.p_int;
		ray.dir.x     = r[0];
		ray.dir.y     = r[1];
		ray.dir.z     = r[2];
		ray.is_shadow = 1'b0;
		return ray;
	endfunction

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	always @(posedge clk) begin : compare
		ray_pkg::ray_t expected;
		if (arst_n && out_valid && !out_stall) begin
			if (expect_q.size() == 0) begin
				$display("an output transfer came with no item expected in %s", test_name);
				$display("TEST FAILED");
				$fatal(1, "unexpected output transfer");
			end else begin
				expected = expect_q.pop_front();
				check({test_name, " ray_id"}, 64'(expected.ray_id), 64'(out_data.ray_id));
				check({test_name, " origin"}, 64'(expected.origin), 64'(out_data.origin));
				check({test_name, " dir"}, 64'(expected.dir), 64'(out_data.dir));
				check({test_name, " is_shadow"}, 64'(expected.is_shadow),
					64'(out_data.is_shadow));
				if (latency_mode) begin
					check({test_name, " cycles"}, 64'(4), 64'(cycle - accept_cycle));
				end
			end
		end
	end

	task automatic run_items(input int n, input bit rand_valid, input bit rand_stall);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(posedge clk);
			if (in_valid && !in_stall) begin
				expect_q.push_back(reflect_ref(in_data));
				accept_cycle = cycle;
				sent++;
			end
			if (sent == n) begin
				in_valid <= 1'b0;
			end else if (!in_valid || !in_stall) begin // stalled item is held.
				if (!rand_valid || rand_bits(1) != 0) begin
					in_valid <= 1'b1;
					in_data  <= make_hit();
				end else begin
					in_valid <= 1'b0;
				end
			end
			out_stall <= rand_stall ? (rand_bits(1) != 0) : 1'b0;
		end
		out_stall <= 1'b0;
	endtask

	task automatic fill_buffer();
		int accepted;
		int quiet;
		accepted = 0;
		quiet    = 0;
		out_stall <= 1'b1;
		while (quiet < 2 * pipe_pkg::reflect_latency + 2) begin
			@(posedge clk);
			if (in_valid && !in_stall) begin
				expect_q.push_back(reflect_ref(in_data));
				accepted++;
				quiet = 0;
			end else if (in_valid) begin
				quiet++;
			end
			if (!in_valid || !in_stall) begin
				in_valid <= 1'b1;
				in_data  <= make_hit();
			end
		end
		check("full_buffer accepted", 64'(pipe_pkg::fifo_depth), 64'(accepted));
		in_valid  <= 1'b0;
		out_stall <= 1'b0;
	endtask

	task automatic wait_drain();
		while (expect_q.size() != 0 || out_valid) begin
			@(posedge clk);
		end
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_data      = '0;
		out_stall    = 1'b0;
		lfsr_state   = 16'd15;
		next_id      = '0;
		cycle        = 0;
		accept_cycle = 0;
		latency_mode = 1'b0;
		test_name    = "reset";
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		test_name = "random_values";
		run_items(n_values, 1'b0, 1'b0);
		wait_drain();

		test_name = "back_pressure";
		run_items(n_backpressure, 1'b1, 1'b1);
		wait_drain();

		test_name = "full_buffer";
		fill_buffer();
		wait_drain();

		test_name    = "latency";
		latency_mode = 1'b1;
		run_items(1, 1'b0, 1'b0);
		wait_drain();
		latency_mode = 1'b0;

		if (expect_q.size() == 0 && !out_valid) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("items were left over after the last test");
			$display("TEST FAILED");
			$fatal(1, "items left after drain");
		end
	end

	initial begin : watchdog
		#((total_items * cycles_per_item + margin_cycles) * clk_period);
		$display("timeout: the tests did not finish in the expected time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule : send_reflect_tb

/* filelist.f */
common/ray_pkg.sv
common/pipe_pkg.sv
send_reflect/reflector.sv
send_reflect/ray_delay_line.sv
send_reflect/ray_fifo.sv
send_reflect/send_reflect.sv
bench/send_reflect_properties.sv
bench/send_reflect_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the send_reflect testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f filelist.f --top-module send_reflect_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vsend_reflect_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
	exit 0
fi
echo "pass message not found"
exit 1
